// File: hdl/rf_cfg.svh
// Widths are fixed for a 39/32 SEC-DED code; the bus map assumes word-aligned byte addresses
`ifndef RF_CFG_SVH
`define RF_CFG_SVH

// Register file geometry
`define RF_NUM_REGS 32
`define RF_DATA_W 32
`define RF_ECC_W 7
`define RF_ADDR_W 5

// Byte address width on the Wishbone side
`define RF_WB_ADDR_W 9

// Window select uses address bits 8:7
`define RF_WIN_MASK 9'h180

// Data of register n at 4n
`define RF_WIN_DATA 9'h000

// Stored check bits of register n at 0x80 + 4n
`define RF_WIN_ECC 9'h080

// Sticky error flag in bit 0, failing index in bits 12:8
`define RF_ADDR_STATUS 9'h100

`endif

// File: hdl/rf_pkg.sv
// Check bits sit above the data in a codeword; check-only writes carry new check bits in low data bits
`include "rf_cfg.svh"

package rf_pkg;

  // Register index, data and check-bit vectors
  typedef logic [`RF_ADDR_W-1:0] rf_addr_t;
  typedef logic [`RF_DATA_W-1:0] rf_data_t;
  typedef logic [`RF_ECC_W-1:0] rf_ecc_t;

  // Stored codeword with check bits on top
  typedef struct packed {
    rf_ecc_t  ecc;
    rf_data_t data;
  } rf_word_t;

  // One-cycle write request from the bus side
  // For check-only writes the low data bits carry the new check bits
  typedef struct packed {
    rf_addr_t addr;
    rf_data_t data;
    logic     we;
    logic     ecc_we;
  } rf_wr_req_t;

  // Bus slave FSM
  typedef enum logic {
    WB_IDLE,
    WB_ACK
  } wb_state_e;

endpackage

// File: hdl/rf_storage.sv
// Entry 0 is hard-wired to the all-zero codeword; full write wins over check-only write
`timescale 1ns/10ps
`include "rf_cfg.svh"

module rf_storage (
  input  logic               clk,
  input  logic               reset_i,
  input  rf_pkg::rf_addr_t   rd_addr_i,
  output rf_pkg::rf_word_t   rd_word_o,
  input  rf_pkg::rf_wr_req_t wr_req_i,
  input  rf_pkg::rf_word_t   wr_word_i
);

  import rf_pkg::*;

  // Only x1..x31 exist as flops
  rf_word_t regs_q [1:`RF_NUM_REGS-1];

  //////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////

  // Reset leaves every entry as a valid zero codeword
  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 1; i < `RF_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      for (int i = 1; i < `RF_NUM_REGS; i++) begin
        if (wr_req_i.addr == rf_addr_t'(i)) begin
          if (wr_req_i.we) begin
            regs_q[i] <= wr_word_i;
          end else if (wr_req_i.ecc_we) begin
            // Diagnostic path, data field untouched
            regs_q[i].ecc <= wr_word_i.ecc;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////

  // Combinational read, x0 always zero with zero check bits
  always_comb begin
    if (rd_addr_i == '0) begin
      rd_word_o = '0;
    end else begin
      rd_word_o = regs_q[rd_addr_i];
    end
  end

endmodule

// File: hdl/rf_ecc.sv
// Detection only: any nonzero syndrome flags an error, nothing is corrected
`timescale 1ns/10ps
`include "rf_cfg.svh"

module rf_ecc (
  input  logic             [`RF_DATA_W-1:0] wr_data_i,
  input  rf_pkg::rf_ecc_t  wr_ecc_i,
  input  logic             wr_check_only_i,
  output rf_pkg::rf_word_t wr_word_o,
  input  rf_pkg::rf_word_t rd_word_i,
  output logic             ecc_err_o
);

  import rf_pkg::*;

  //////////////////////////////////////////////////
  // Hsiao parity-check matrix
  //////////////////////////////////////////////////

  // One column per data bit, all distinct and of weight 3
  // Check bits themselves have weight-1 columns
  function automatic logic [`RF_DATA_W-1:0][`RF_ECC_W-1:0] gen_cols();
    logic [`RF_DATA_W-1:0][`RF_ECC_W-1:0] cols;
    int unsigned n;
    cols = '0;
    n = 0;
    // 35 weight-3 patterns exist, take the first 32
    for (int unsigned v = 1; v < (1 << `RF_ECC_W); v++) begin
      if (($countones(v) == 3) && (n < `RF_DATA_W)) begin
        cols[n] = rf_ecc_t'(v);
        n++;
      end
    end
    return cols;
  endfunction

  localparam logic [`RF_DATA_W-1:0][`RF_ECC_W-1:0] hsiao_cols = gen_cols();

  // Parity of the data bits against the column set
  function automatic rf_ecc_t calc_parity(input rf_data_t d);
    rf_ecc_t p;
    p = '0;
    for (int i = 0; i < `RF_DATA_W; i++) begin
      if (d[i]) begin
        p = p ^ hsiao_cols[i];
      end
    end
    return p;
  endfunction

  //////////////////////////////////////////////////
  // Encoder
  //////////////////////////////////////////////////

  // All-zero data encodes to all-zero check bits
  // Check-only writes pass the supplied bits through untouched
  always_comb begin
    wr_word_o.data = wr_data_i;
    if (wr_check_only_i) begin
      wr_word_o.ecc = wr_ecc_i;
    end else begin
      wr_word_o.ecc = calc_parity(wr_data_i);
    end
  end

  //////////////////////////////////////////////////
  // Checker
  //////////////////////////////////////////////////

  rf_ecc_t syndrome;

  // Single flips give odd weight, double flips even but nonzero
  assign syndrome  = calc_parity(rd_word_i.data) ^ rd_word_i.ecc;
  assign ecc_err_o = |syndrome;

endmodule

// File: hdl/rf_wrapper.sv
// Single read port and single write port; a write is seen by a read one cycle later
`timescale 1ns/10ps
`include "rf_cfg.svh"

module rf_wrapper (
  // Clock and reset
  input  logic               clk,
  input  logic               reset_i,

  // Read port
  input  rf_pkg::rf_addr_t   rd_addr_i,
  output rf_pkg::rf_data_t   rd_data_o,
  output rf_pkg::rf_ecc_t    rd_ecc_o,

  // Error from the read checker
  output logic               ecc_err_o,

  // Write port
  input  rf_pkg::rf_wr_req_t wr_req_i
);

  import rf_pkg::*;

  // Encoded write word and raw read word
  rf_word_t wr_word;
  rf_word_t rd_word;

  // Encoder and checker share one block
  // check bits for a diagnostic write sit in the low data bits
  rf_ecc u_ecc (
    .wr_data_i       (wr_req_i.data),
    .wr_ecc_i        (wr_req_i.data[`RF_ECC_W-1:0]),
    .wr_check_only_i (wr_req_i.ecc_we),
    .wr_word_o       (wr_word),
    .rd_word_i       (rd_word),
    .ecc_err_o       (ecc_err_o)
  );

  // Codeword array
  rf_storage u_storage (
    .clk       (clk),
    .reset_i   (reset_i),
    .rd_addr_i (rd_addr_i),
    .rd_word_o (rd_word),
    .wr_req_i  (wr_req_i),
    .wr_word_i (wr_word)
  );

  // Strip check bits for the data path
  assign rd_data_o = rd_word.data;

  // Stored check bits, diagnostic window only
  assign rd_ecc_o  = rd_word.ecc;

endmodule

// File: hdl/rf_wb_slave.sv
// Wishbone classic, one access per two cycles; byte selects and adr bits 1:0 are ignored
`timescale 1ns/10ps
`include "rf_cfg.svh"

module rf_wb_slave (
  input  logic                     clk,
  input  logic                     reset_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [`RF_WB_ADDR_W-1:0] wb_adr_i,
  input  rf_pkg::rf_data_t         wb_dat_i,
  output rf_pkg::rf_data_t         wb_dat_o,
  output logic                     wb_ack_o,
  output rf_pkg::rf_addr_t         rd_addr_o,
  input  rf_pkg::rf_data_t         rd_data_i,
  input  rf_pkg::rf_ecc_t          rd_ecc_i,
  input  logic                     ecc_err_i,
  output rf_pkg::rf_wr_req_t       wr_req_o,
  output logic                     ecc_irq_o
);

  import rf_pkg::*;

  wb_state_e state_q;
  logic      access;
  logic      sel_data;
  logic      sel_ecc;
  logic      sel_status;
  rf_addr_t  idx;
  rf_data_t  status_word;
  rf_data_t  rdata_d;
  rf_data_t  rdata_q;
  logic      err_q;
  rf_addr_t  err_idx_q;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  // Strobe ignored in the ack cycle, no double access
  assign access     = wb_cyc_i & wb_stb_i & (state_q == WB_IDLE);
  assign sel_data   = (wb_adr_i & `RF_WIN_MASK) == `RF_WIN_DATA;
  assign sel_ecc    = (wb_adr_i & `RF_WIN_MASK) == `RF_WIN_ECC;
  assign sel_status = wb_adr_i == `RF_ADDR_STATUS;
  assign idx        = rf_addr_t'(wb_adr_i[`RF_ADDR_W+1:2]);
  assign rd_addr_o  = idx;

  // Write lands on the sampling edge
  always_comb begin
    wr_req_o.addr   = idx;
    wr_req_o.data   = wb_dat_i;
    wr_req_o.we     = access & wb_we_i & sel_data;
    wr_req_o.ecc_we = access & wb_we_i & sel_ecc;
  end

  // Status layout, flag in bit 0 and index in 12:8
  always_comb begin
    status_word        = '0;
    status_word[0]     = err_q;
    status_word[12:8]  = err_idx_q;
  end

  // Read mux, unmapped reads give zero
  always_comb begin
    if (sel_data) begin
      rdata_d = rd_data_i;
    end else if (sel_ecc) begin
      rdata_d = rf_data_t'(rd_ecc_i);
    end else if (sel_status) begin
      rdata_d = status_word;
    end else begin
      rdata_d = '0;
    end
  end

  //////////////////////////////////////////////////
  // Handshake FSM and status
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q   <= WB_IDLE;
      err_q     <= 1'b0;
      err_idx_q <= '0;
    end else begin
      case (state_q)
        WB_IDLE: if (access) state_q <= WB_ACK;
        default: state_q <= WB_IDLE;
      endcase
      // First failing index is kept until cleared
      if (access && !wb_we_i && sel_data && ecc_err_i && !err_q) begin
        err_q     <= 1'b1;
        err_idx_q <= idx;
      end else if (access && wb_we_i && sel_status && wb_dat_i[0]) begin
        err_q     <= 1'b0;
        err_idx_q <= '0;
      end
    end
  end

  // Read data held through the ack cycle
  always_ff @(posedge clk) begin
    if (access && !wb_we_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign wb_ack_o  = state_q == WB_ACK;
  assign wb_dat_o  = rdata_q;
  assign ecc_irq_o = err_q;

endmodule

// File: hdl/rf_top.sv
// Wishbone classic slave only; ecc_irq_o is level, held until the status flag is cleared
`timescale 1ns/10ps
`include "rf_cfg.svh"

module rf_top (
  input  logic                     clk,
  input  logic                     reset_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [`RF_WB_ADDR_W-1:0] wb_adr_i,
  input  rf_pkg::rf_data_t         wb_dat_i,
  output rf_pkg::rf_data_t         wb_dat_o,
  output logic                     wb_ack_o,
  output logic                     ecc_irq_o
);

  import rf_pkg::*;

  // Slave to wrapper
  rf_addr_t   rd_addr;
  rf_wr_req_t wr_req;

  // Wrapper back to slave
  rf_data_t   rd_data;
  rf_ecc_t    rd_ecc;
  logic       ecc_err;

  // Bus front end and status
  rf_wb_slave u_wb_slave (
    .clk       (clk),
    .reset_i   (reset_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .rd_addr_o (rd_addr),
    .rd_data_i (rd_data),
    .rd_ecc_i  (rd_ecc),
    .ecc_err_i (ecc_err),
    .wr_req_o  (wr_req),
    .ecc_irq_o (ecc_irq_o)
  );

  // Protected register file
  rf_wrapper u_wrapper (
    .clk       (clk),
    .reset_i   (reset_i),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data),
    .rd_ecc_o  (rd_ecc),
    .ecc_err_o (ecc_err),
    .wr_req_i  (wr_req)
  );

endmodule

// File: verification/rf_tb.sv
// Run from the project root so the golden file path resolves; single master, no pipelined cycles
`timescale 1ns/10ps
`include "rf_cfg.svh"

module rf_tb;

  import rf_pkg::*;

  localparam int ACK_LIMIT = 20;

  logic                     clk;
  logic                     reset_i;
  logic                     wb_cyc_i;
  logic                     wb_stb_i;
  logic                     wb_we_i;
  logic [`RF_WB_ADDR_W-1:0] wb_adr_i;
  rf_data_t                 wb_dat_i;
  rf_data_t                 wb_dat_o;
  logic                     wb_ack_o;
  logic                     ecc_irq_o;

  // Bookkeeping
  int       pass_cnt;
  int       fail_cnt;
  bit       test_bad;
  bit       aborted;
  string    cur_test;
  rf_data_t saved [int];
  rf_data_t rand_vals [1:`RF_NUM_REGS-1];

  rf_top dut0 (
    .clk       (clk),
    .reset_i   (reset_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .ecc_irq_o (ecc_irq_o)
  );

  // 100 ns period
  always #50 clk = ~clk;

  //////////////////////////////////////////////////
  // Test bookkeeping
  //////////////////////////////////////////////////

  task automatic start_test(input string name);
    cur_test = name;
    test_bad = 1'b0;
  endtask

  // One line per finished test
  task automatic end_test();
    if (test_bad) begin
      fail_cnt++;
      $display("test %s: mismatch", cur_test);
    end else begin
      pass_cnt++;
      $display("test %s: ok", cur_test);
    end
  endtask

  task automatic compare(input rf_data_t exp, input rf_data_t act);
    if (exp !== act) begin
      test_bad = 1'b1;
      $display("FAILED %s: expected %h, actual %h", cur_test, exp, act);
    end
  endtask

  // Stops all further bus traffic
  task automatic no_ack();
    test_bad = 1'b1;
    aborted  = 1'b1;
    $display("test %s: no acknowledge from the DUT within %0d cycles", cur_test, ACK_LIMIT);
  endtask

  //////////////////////////////////////////////////
  // Wishbone master
  //////////////////////////////////////////////////

  task automatic idle_bus();
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
  endtask

  // Entered 5 ns after an edge and samples ack 5 ns after each later edge
  task automatic bus_cycle(input logic we, input logic [`RF_WB_ADDR_W-1:0] adr,
                           input rf_data_t wdat, output rf_data_t rdat);
    bit got_ack;
    got_ack = 1'b0;
    rdat    = 'x;
    if (!aborted) begin
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = wdat;
      for (int i = 0; i < ACK_LIMIT && !got_ack; i++) begin
        @(posedge clk);
        #5;
        if (wb_ack_o) begin
          got_ack = 1'b1;
          rdat    = wb_dat_o;
        end
      end
      idle_bus();
      if (!got_ack) begin
        no_ack();
      end
    end
  endtask

  task automatic bus_write(input logic [`RF_WB_ADDR_W-1:0] adr, input rf_data_t wdat);
    rf_data_t unused;
    bus_cycle(1'b1, adr, wdat, unused);
  endtask

  task automatic bus_read(input logic [`RF_WB_ADDR_W-1:0] adr, output rf_data_t rdat);
    bus_cycle(1'b0, adr, '0, rdat);
  endtask

  //////////////////////////////////////////////////
  // Test sequences
  //////////////////////////////////////////////////

  // Everything zero out of reset
  task automatic reset_sweep();
    rf_data_t rdat;
    start_test("reset_sweep");
    for (int r = 0; r < `RF_NUM_REGS; r++) begin
      bus_read(`RF_WIN_DATA + 9'(4 * r), rdat);
      compare('0, rdat);
    end
    bus_read(`RF_ADDR_STATUS, rdat);
    compare('0, rdat);
    compare('0, rf_data_t'(ecc_irq_o));
    end_test();
  endtask

  // One bus operation per line with saved reads kept by address for cap and wx
  task automatic run_golden();
    int                       fd;
    int                       code;
    string                    name;
    string                    op;
    string                    rest;
    logic [`RF_WB_ADDR_W-1:0] adr;
    rf_data_t                 wdat;
    rf_data_t                 exp;
    rf_data_t                 rdat;
    fd = $fopen("verification/rf_golden.txt", "r");
    if (fd == 0) begin
      fail_cnt++;
      aborted = 1'b1;
      $display("cannot open verification/rf_golden.txt");
    end else begin
      while (!aborted && $fscanf(fd, "%s", name) == 1) begin
        if (name.getc(0) == "#") begin
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, "%s %h %h %h", op, adr, wdat, exp);
          start_test(name);
          if (code != 4) begin
            test_bad = 1'b1;
            $display("test %s: golden line is incomplete", name);
          end else begin
            case (op)
              "wr":  bus_write(adr, wdat);
              "rd": begin
                bus_read(adr, rdat);
                compare(exp, rdat);
              end
              "cap": begin
                bus_read(adr, rdat);
                saved[int'(adr)] = rdat;
              end
              "wx":  bus_write(adr, saved[int'(adr)] ^ wdat);
              "irq": compare(exp, rf_data_t'(ecc_irq_o));
              default: begin
                test_bad = 1'b1;
                $display("test %s: unknown operation %s", name, op);
              end
            endcase
          end
          end_test();
        end
      end
      $fclose(fd);
    end
  endtask

  // Random data through every register while x0 stays zero
  task automatic random_fill();
    rf_data_t rdat;
    start_test("random_fill");
    for (int r = 1; r < `RF_NUM_REGS; r++) begin
      rand_vals[r] = $urandom();
      bus_write(`RF_WIN_DATA + 9'(4 * r), rand_vals[r]);
    end
    bus_write(`RF_WIN_DATA, $urandom());
    for (int r = 0; r < `RF_NUM_REGS; r++) begin
      bus_read(`RF_WIN_DATA + 9'(4 * r), rdat);
      compare((r == 0) ? '0 : rand_vals[r], rdat);
    end
    // Clean reads leave the status alone
    bus_read(`RF_ADDR_STATUS, rdat);
    compare('0, rdat);
    end_test();
  endtask

  // Strobe kept high through the ack edge
  task automatic held_strobe();
    int       acks;
    bit       prev;
    bit       double_ack;
    bit       got;
    rf_data_t rdat;
    start_test("held_strobe");
    acks       = 0;
    double_ack = 1'b0;
    got        = 1'b0;
    wb_cyc_i   = 1'b1;
    wb_stb_i   = 1'b1;
    wb_we_i    = 1'b1;
    wb_adr_i   = `RF_WIN_DATA + 9'h024;
    wb_dat_i   = 32'h600d_cafe;
    for (int i = 0; i < ACK_LIMIT && !got; i++) begin
      @(posedge clk);
      #5;
      got = wb_ack_o;
    end
    if (!got) begin
      idle_bus();
      no_ack();
    end else begin
      acks = 1;
      prev = 1'b1;
      // Other data in the ack cycle would land only through a second write
      wb_dat_i = 32'h0bad_0bad;
      // Watch a few cycles and drop the strobe after the first
      for (int i = 0; i < 4; i++) begin
        @(posedge clk);
        #5;
        if (wb_ack_o) begin
          acks++;
        end
        if (wb_ack_o && prev) begin
          double_ack = 1'b1;
        end
        prev = wb_ack_o;
        if (i == 0) begin
          idle_bus();
        end
      end
      compare(32'd1, rf_data_t'(acks));
      compare('0, rf_data_t'(double_ack));
      bus_read(`RF_WIN_DATA + 9'h024, rdat);
      compare(32'h600d_cafe, rdat);
    end
    end_test();
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int seed;
    clk      = 1'b0;
    reset_i  = 1'b1;
    pass_cnt = 0;
    fail_cnt = 0;
    test_bad = 1'b0;
    aborted  = 1'b0;
    idle_bus();
    seed = $urandom(32'h52da);
    repeat (16) @(posedge clk);
    #5;
    reset_i = 1'b0;
    reset_sweep();
    run_golden();
    if (!aborted) begin
      random_fill();
    end
    if (!aborted) begin
      held_strobe();
    end
    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: verification/rf_golden.txt
# name op addr wdata expect, all numbers hex; op is wr, rd, cap (save read), wx (write saved xor wdata)
# irq compares ecc_irq_o with expect; status is flag in bit 0 and failing index in bits 12:8
x1_wr         wr   004 a5a5a5a5 00000000
x1_rd         rd   004 00000000 a5a5a5a5
x2_wr         wr   008 12345678 00000000
x2_rd         rd   008 00000000 12345678
x31_wr        wr   07c ffffffff 00000000
x31_rd        rd   07c 00000000 ffffffff
x0_wr         wr   000 deadbeef 00000000
x0_rd         rd   000 00000000 00000000
x4_zero_wr    wr   010 00000000 00000000
x4_ecc_rd     rd   090 00000000 00000000
x3_wr         wr   00c cafef00d 00000000
x3_ecc_cap    cap  08c 00000000 00000000
x3_flip1      wx   08c 00000001 00000000
x3_rd_err     rd   00c 00000000 cafef00d
x3_status     rd   100 00000000 00000301
x3_irq        irq  000 00000000 00000001
x5_wr         wr   014 0badc0de 00000000
x5_ecc_cap    cap  094 00000000 00000000
x5_flip1      wx   094 00000010 00000000
x5_rd_err     rd   014 00000000 0badc0de
x5_status     rd   100 00000000 00000301
st_clear      wr   100 00000001 00000000
st_clear_rd   rd   100 00000000 00000000
irq_clear     irq  000 00000000 00000000
x3_restore    wx   08c 00000000 00000000
x5_restore    wx   094 00000000 00000000
x3_rd_clean   rd   00c 00000000 cafef00d
x5_rd_clean   rd   014 00000000 0badc0de
st_clean      rd   100 00000000 00000000
x7_wr         wr   01c 76543210 00000000
x7_ecc_cap    cap  09c 00000000 00000000
x7_flip2      wx   09c 00000003 00000000
x7_rd_err     rd   01c 00000000 76543210
x7_status     rd   100 00000000 00000701
x7_irq        irq  000 00000000 00000001
st_clear2     wr   100 00000001 00000000
x7_restore    wx   09c 00000000 00000000
x7_rd_clean   rd   01c 00000000 76543210
st_clean2     rd   100 00000000 00000000
irq_clear2    irq  000 00000000 00000000
unmap_rd      rd   180 00000000 00000000
unmap_rd2     rd   104 00000000 00000000
unmap_wr      wr   1fc ffffffff 00000000
unmap_rd3     rd   1fc 00000000 00000000

// File: sim.f
+incdir+hdl
hdl/rf_pkg.sv
hdl/rf_storage.sv
hdl/rf_ecc.sv
hdl/rf_wrapper.sv
hdl/rf_wb_slave.sv
hdl/rf_top.sv
verification/rf_tb.sv

// File: Bender.yml
package:
  name: rf_ecc_regfile

export_include_dirs:
  - hdl

sources:
  - hdl/rf_pkg.sv
  - hdl/rf_storage.sv
  - hdl/rf_ecc.sv
  - hdl/rf_wrapper.sv
  - hdl/rf_wb_slave.sv
  - hdl/rf_top.sv
  - target: test
    files:
      - verification/rf_tb.sv
